// ==== tlu_cfg.svh ====
////////////////////////////////////////
// trigger unit configuration macros
// widths, lane count, fifo depth
// register map and reset values
////////////////////////////////////////
`ifndef TLU_CFG_SVH
`define TLU_CFG_SVH

`define TLU_LANES        8
`define TLU_ADDR_W       16
`define TLU_DATA_W       8
`define TLU_WORD_W       32
`define TLU_FIFO_DEPTH   8
`define TLU_SYNC_STAGES  3
`define TLU_VERSION      8'd2

// address 12 reads lost count and writes trigger select
`define TLU_ADDR_RST_VER   16'd0   // write resets, read gives version
`define TLU_ADDR_CONF      16'd1   // bit 7 selects timestamp words
`define TLU_ADDR_CNT0      16'd8
`define TLU_ADDR_CNT1      16'd9
`define TLU_ADDR_CNT2      16'd10
`define TLU_ADDR_CNT3      16'd11  // write here loads the counter
`define TLU_ADDR_LOST      16'd12
`define TLU_ADDR_TRIG_SEL  16'd12
`define TLU_ADDR_VETO_SEL  16'd13
`define TLU_ADDR_TRIG_INV  16'd14

`define TLU_TRIG_SEL_RST   8'h00
`define TLU_VETO_SEL_RST   8'hff   // every lane may veto
`define TLU_TRIG_INV_RST   8'h00

`endif

// ==== tlu_reg_pkg.sv ====
////////////////////////////////////////
// register side types
// bus request and configuration struct
////////////////////////////////////////
`include "tlu_cfg.svh"

package tlu_reg_pkg;

    // one bus cycle as the register file sees it
    typedef struct packed {
        logic [`TLU_ADDR_W-1:0] addr;
        logic [`TLU_DATA_W-1:0] data;  // write data
        logic                   rd;
        logic                   wr;
    } bus_req_t;

    // everything the trigger path reads from the registers
    typedef struct packed {
        logic [`TLU_LANES-1:0] trig_select;
        logic [`TLU_LANES-1:0] veto_select;
        logic [`TLU_LANES-1:0] trig_invert;
        logic                  write_ts;  // timestamp in word instead of count
    } tlu_conf_t;

endpackage

// ==== tlu_data_pkg.sv ====
////////////////////////////////////////
// trigger path types
// lane output, trigger word
// and fifo status
////////////////////////////////////////
`include "tlu_cfg.svh"

package tlu_data_pkg;

    // one lane after masking
    typedef struct packed {
        logic trig;
        logic veto;
    } lane_out_t;

    // word pushed for every accepted trigger
    typedef struct packed {
        logic                   marker;  // always set
        logic [`TLU_WORD_W-2:0] data;    // count or timestamp
    } trig_word_t;

    typedef struct packed {
        logic       empty;
        logic       full;
        logic [7:0] lost;   // words dropped on a full fifo
    } fifo_stat_t;

endpackage

// ==== tlu_regs.sv ====
////////////////////////////////////////
// register file of the trigger unit
// soft reset, config registers,
// counter load and latched readback
////////////////////////////////////////
`include "tlu_cfg.svh"

module tlu_regs
    import tlu_reg_pkg::*, tlu_data_pkg::*;
(
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  bus_req_t               bus,
    input  logic [`TLU_WORD_W-1:0] counter,
    input  fifo_stat_t             fifo_stat,
    output tlu_conf_t              conf,
    output logic                   soft_rst,
    output logic                   cnt_load,
    output logic [`TLU_WORD_W-1:0] cnt_load_value,
    output logic [`TLU_DATA_W-1:0] BUS_DATA_OUT
);

    logic                   rst_i;
    logic                   write_ts;
    logic [`TLU_LANES-1:0]  trig_sel;
    logic [`TLU_LANES-1:0]  veto_sel;
    logic [`TLU_LANES-1:0]  trig_inv;
    logic [`TLU_DATA_W-1:0] cnt_b0;
    logic [`TLU_DATA_W-1:0] cnt_b1;
    logic [`TLU_DATA_W-1:0] cnt_b2;
    logic [`TLU_WORD_W-1:8] cnt_buf;    // upper bytes frozen by a read of byte 0

    // write to address 0 gives a single cycle pulse
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= bus.wr && (bus.addr == `TLU_ADDR_RST_VER);
    end

    assign rst_i = RST | soft_rst;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_i)
        begin
            write_ts <= 1'b0;
            trig_sel <= `TLU_TRIG_SEL_RST;
            veto_sel <= `TLU_VETO_SEL_RST;
            trig_inv <= `TLU_TRIG_INV_RST;
            cnt_b0   <= '0;
            cnt_b1   <= '0;
            cnt_b2   <= '0;
        end
        else if (bus.wr)
        begin
            case (bus.addr)
                `TLU_ADDR_CONF:     write_ts <= bus.data[7];
                `TLU_ADDR_CNT0:     cnt_b0   <= bus.data;
                `TLU_ADDR_CNT1:     cnt_b1   <= bus.data;
                `TLU_ADDR_CNT2:     cnt_b2   <= bus.data;
                `TLU_ADDR_TRIG_SEL: trig_sel <= bus.data;
                `TLU_ADDR_VETO_SEL: veto_sel <= bus.data;
                `TLU_ADDR_TRIG_INV: trig_inv <= bus.data;
                default: ;
            endcase
        end
    end

    assign conf.trig_select = trig_sel;
    assign conf.veto_select = veto_sel;
    assign conf.trig_invert = trig_inv;
    assign conf.write_ts    = write_ts;

    // top byte comes straight from the bus
    assign cnt_load       = bus.wr && (bus.addr == `TLU_ADDR_CNT3);
    assign cnt_load_value = {bus.data, cnt_b2, cnt_b1, cnt_b0};

    always_ff @(posedge BUS_CLK)
    begin
        if (bus.rd && (bus.addr == `TLU_ADDR_CNT0))
            cnt_buf <= counter[`TLU_WORD_W-1:8];
    end

    always_ff @(posedge BUS_CLK)
    begin
        case (bus.addr)
            `TLU_ADDR_RST_VER:  BUS_DATA_OUT <= `TLU_VERSION;
            `TLU_ADDR_CONF:     BUS_DATA_OUT <= {write_ts, 7'b0};
            `TLU_ADDR_CNT0:     BUS_DATA_OUT <= counter[7:0];   // live value
            `TLU_ADDR_CNT1:     BUS_DATA_OUT <= cnt_buf[15:8];
            `TLU_ADDR_CNT2:     BUS_DATA_OUT <= cnt_buf[23:16];
            `TLU_ADDR_CNT3:     BUS_DATA_OUT <= cnt_buf[31:24];
            `TLU_ADDR_LOST:     BUS_DATA_OUT <= fifo_stat.lost;
            `TLU_ADDR_VETO_SEL: BUS_DATA_OUT <= veto_sel;
            `TLU_ADDR_TRIG_INV: BUS_DATA_OUT <= trig_inv;
            default:            BUS_DATA_OUT <= '0;
        endcase
    end

    // bus master issues one access per cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge BUS_CLK) disable iff (RST)
            !(bus.wr && bus.rd)
    );

endmodule

// ==== trigger_lane.sv ====
////////////////////////////////////////
// one trigger input lane
// pin synchronizer, invert, masks
////////////////////////////////////////
`include "tlu_cfg.svh"

module trigger_lane
    import tlu_reg_pkg::*, tlu_data_pkg::*;
#(
    parameter int LANE = 0
)
(
    input  logic      BUS_CLK,
    input  logic      RST,
    input  tlu_conf_t conf,
    input  logic      trig_pin,
    input  logic      veto_pin,
    output lane_out_t lane
);

    logic [`TLU_SYNC_STAGES-1:0] trig_sync;
    logic [`TLU_SYNC_STAGES-1:0] veto_sync;
    logic                        trig_s;
    logic                        veto_s;

    // shift in at bit 0, use the top stage
    always_ff @(posedge BUS_CLK)
    begin
        trig_sync <= {trig_sync[`TLU_SYNC_STAGES-2:0], trig_pin};
        veto_sync <= {veto_sync[`TLU_SYNC_STAGES-2:0], veto_pin};
    end

    assign trig_s = trig_sync[`TLU_SYNC_STAGES-1] ^ conf.trig_invert[LANE];
    assign veto_s = veto_sync[`TLU_SYNC_STAGES-1];

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            lane <= '0;
        else
        begin
            lane.trig <= trig_s & conf.trig_select[LANE];
            lane.veto <= veto_s & conf.veto_select[LANE];  // no invert on veto
        end
    end

endmodule

// ==== trigger_accept.sv ====
////////////////////////////////////////
// trigger acceptance
// lane combiner and edge detect,
// accept/acknowledge handshake,
// trigger counter, timestamp, word
////////////////////////////////////////
`include "tlu_cfg.svh"

module trigger_accept
    import tlu_data_pkg::*;
(
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  lane_out_t              lanes [`TLU_LANES],
    input  logic                   write_ts,
    input  logic                   TRIGGER_ENABLE,
    input  logic                   TRIGGER_ACKNOWLEDGE,
    input  logic                   cnt_load,
    input  logic [`TLU_WORD_W-1:0] cnt_load_value,
    output logic                   TRIGGER_ACCEPTED_FLAG,
    output logic                   TLU_BUSY,
    output logic [`TLU_WORD_W-1:0] counter,
    output logic                   push,
    output trig_word_t             word,
    output logic [`TLU_WORD_W-1:0] TIMESTAMP
);

    logic trig_any;
    logic veto_any;
    logic trig_prev;
    logic idle;
    logic accept;

    always_comb
    begin
        trig_any = 1'b0;
        veto_any = 1'b0;
        for (int i = 0; i < `TLU_LANES; i++)
        begin
            trig_any |= lanes[i].trig;
            veto_any |= lanes[i].veto;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            trig_prev <= 1'b0;
        else
            trig_prev <= trig_any;
    end

    // handshake idle only when both sides are low
    assign idle     = !TRIGGER_ACCEPTED_FLAG && !TRIGGER_ACKNOWLEDGE;
    assign accept   = trig_any && !trig_prev && TRIGGER_ENABLE && !veto_any && idle;
    assign TLU_BUSY = !idle;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            TRIGGER_ACCEPTED_FLAG <= 1'b0;
        else if (accept)
            TRIGGER_ACCEPTED_FLAG <= 1'b1;
        else if (TRIGGER_ACCEPTED_FLAG && TRIGGER_ACKNOWLEDGE)
            TRIGGER_ACCEPTED_FLAG <= 1'b0;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            counter <= '0;
        else if (cnt_load)
            counter <= cnt_load_value;   // software load wins
        else if (accept && (counter != '1))
            counter <= counter + 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            TIMESTAMP <= '0;
        else
            TIMESTAMP <= TIMESTAMP + 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            push <= 1'b0;
        else
            push <= accept;   // high while the flag is first high
    end

    // count taken before the increment above
    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
        begin
            word.marker <= 1'b1;
            word.data   <= write_ts ? TIMESTAMP[`TLU_WORD_W-2:0] : counter[`TLU_WORD_W-2:0];
        end
    end

    // acknowledge only answers a raised flag
    a_ack_after_flag: assert property (
        @(posedge BUS_CLK) disable iff (RST)
            $rose(TRIGGER_ACKNOWLEDGE) |-> TRIGGER_ACCEPTED_FLAG
    );

endmodule

// ==== trigger_fifo.sv ====
////////////////////////////////////////
// output fifo for trigger words
// with saturating lost data counter
////////////////////////////////////////
`include "tlu_cfg.svh"

module trigger_fifo
    import tlu_data_pkg::*;
(
    input  logic       BUS_CLK,
    input  logic       RST,
    input  logic       push,
    input  trig_word_t word,
    input  logic       FIFO_READ,
    output trig_word_t FIFO_DATA,
    output logic       FIFO_EMPTY,
    output fifo_stat_t stat
);

    localparam int AW = $clog2(`TLU_FIFO_DEPTH);
    localparam logic [AW:0] DEPTH = `TLU_FIFO_DEPTH;

    trig_word_t    mem [`TLU_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [7:0]    lost_cnt;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full       = (count == DEPTH);
    assign FIFO_EMPTY = (count == '0);
    assign do_push    = push && !full;
    assign do_pop     = FIFO_READ && !FIFO_EMPTY;   // reads on empty ignored

    always_ff @(posedge BUS_CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= word;
    end

    assign FIFO_DATA = mem[rd_ptr];   // head shown without a read

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            lost_cnt <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // full fifo drops the word
            if (push && full && (lost_cnt != 8'hff))
                lost_cnt <= lost_cnt + 1'b1;
        end
    end

    assign stat.empty = FIFO_EMPTY;
    assign stat.full  = full;
    assign stat.lost  = lost_cnt;

    // reader pops only a fifo that holds a word
    a_no_pop_empty: assert property (
        @(posedge BUS_CLK) disable iff (RST)
            FIFO_READ |-> !FIFO_EMPTY
    );

endmodule

// ==== tlu_core.sv ====
////////////////////////////////////////
// trigger unit top level
// register file, eight input lanes,
// acceptance logic and output fifo
////////////////////////////////////////
`include "tlu_cfg.svh"

module tlu_core
    import tlu_reg_pkg::*, tlu_data_pkg::*;
(
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  logic [`TLU_ADDR_W-1:0] BUS_ADD,
    input  logic [`TLU_DATA_W-1:0] BUS_DATA_IN,
    input  logic                   BUS_RD,
    input  logic                   BUS_WR,
    output logic [`TLU_DATA_W-1:0] BUS_DATA_OUT,
    input  logic                   FIFO_READ,
    output logic                   FIFO_EMPTY,
    output logic [`TLU_WORD_W-1:0] FIFO_DATA,
    input  logic [`TLU_LANES-1:0]  TRIGGER,
    input  logic [`TLU_LANES-1:0]  TRIGGER_VETO,
    input  logic                   TRIGGER_ENABLE,
    input  logic                   TRIGGER_ACKNOWLEDGE,
    output logic                   TRIGGER_ACCEPTED_FLAG,
    output logic                   TLU_BUSY,
    output logic [`TLU_WORD_W-1:0] TIMESTAMP
);

    bus_req_t               bus;
    tlu_conf_t              conf;
    logic                   soft_rst;
    logic                   int_rst;    // pin reset or register reset
    logic                   cnt_load;
    logic [`TLU_WORD_W-1:0] cnt_load_value;
    logic [`TLU_WORD_W-1:0] counter;
    lane_out_t              lanes [`TLU_LANES];
    logic                   push;
    trig_word_t             word;
    fifo_stat_t             fifo_stat;

    assign bus     = '{addr: BUS_ADD, data: BUS_DATA_IN, rd: BUS_RD, wr: BUS_WR};
    assign int_rst = RST | soft_rst;

    tlu_regs regs0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus(bus), .counter(counter),
        .fifo_stat(fifo_stat), .conf(conf), .soft_rst(soft_rst),
        .cnt_load(cnt_load), .cnt_load_value(cnt_load_value),
        .BUS_DATA_OUT(BUS_DATA_OUT)
    );

    for (genvar i = 0; i < `TLU_LANES; i++)
    begin : g_lane
        trigger_lane #(.LANE(i)) lane0 (
            .BUS_CLK(BUS_CLK), .RST(int_rst), .conf(conf),
            .trig_pin(TRIGGER[i]), .veto_pin(TRIGGER_VETO[i]), .lane(lanes[i])
        );
    end

    trigger_accept accept0 (
        .BUS_CLK(BUS_CLK), .RST(int_rst), .lanes(lanes), .write_ts(conf.write_ts),
        .TRIGGER_ENABLE(TRIGGER_ENABLE), .TRIGGER_ACKNOWLEDGE(TRIGGER_ACKNOWLEDGE),
        .cnt_load(cnt_load), .cnt_load_value(cnt_load_value),
        .TRIGGER_ACCEPTED_FLAG(TRIGGER_ACCEPTED_FLAG), .TLU_BUSY(TLU_BUSY),
        .counter(counter), .push(push), .word(word), .TIMESTAMP(TIMESTAMP)
    );

    trigger_fifo fifo0 (
        .BUS_CLK(BUS_CLK), .RST(int_rst), .push(push), .word(word),
        .FIFO_READ(FIFO_READ), .FIFO_DATA(FIFO_DATA), .FIFO_EMPTY(FIFO_EMPTY),
        .stat(fifo_stat)
    );

endmodule

// ==== tb_tlu_checker.sv ====
////////////////////////////////////////
// testbench checker
// counts handshakes, collects popped
// fifo words, compares and reports
////////////////////////////////////////
`include "tlu_cfg.svh"

module tb_tlu_checker
(
    input logic        BUS_CLK,
    input logic        TRIGGER_ACCEPTED_FLAG,
    input logic        FIFO_READ,
    input logic        FIFO_EMPTY,
    input logic [31:0] FIFO_DATA,
    input logic [31:0] TIMESTAMP
);
    timeunit 1ns;
    timeprecision 100ps;

    string       test_name;
    int          rises = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        flag_q = 1'b0;
    logic [31:0] words [$];
    logic [31:0] stamps [$];   // expected words in timestamp mode

    always @(posedge BUS_CLK)
    begin
        if (TRIGGER_ACCEPTED_FLAG && !flag_q)
        begin
            rises++;                    // one per handshake
            // stamp was taken one cycle before the flag rose
            stamps.push_back((TIMESTAMP - 32'd1) | 32'h8000_0000);
        end
        flag_q = TRIGGER_ACCEPTED_FLAG;
        if (FIFO_READ && !FIFO_EMPTY)
            words.push_back(FIFO_DATA); // head word as it leaves
    end

    task automatic start_test(input string name);
        test_name = name;
        rises = 0;
        test_errors = 0;
        words.delete();
        stamps.delete();
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp)
        begin
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic end_test(input int exp_count, input logic [31:0] exp_first,
                            input logic ts_mode);
        int n_words;
        n_words = (exp_count > `TLU_FIFO_DEPTH) ? `TLU_FIFO_DEPTH : exp_count;
        check_value("handshakes", exp_count, rises);
        check_value("fifo words", n_words, words.size());
        for (int i = 0; i < words.size(); i++)
        begin
            if (ts_mode)
            begin
                check_value("marker bit", 1, words[i][31]);
                check_value("timestamp word", stamps[i], words[i]);
                if (i > 0 && words[i][30:0] <= words[i-1][30:0])
                    note_error("timestamp words are not strictly increasing");
            end
            else
                check_value("trigger word", exp_first + i, words[i]);  // count goes up by one
        end
        tests_run++;
        errors += test_errors;
        if (test_errors == 0)
            $display("test %-12s passed", test_name);
        else
        begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    endtask

endmodule

// ==== tb_tlu.sv ====
////////////////////////////////////////
// testbench top for the trigger unit
// clock, reset, stimulus table,
// bus tasks, trigger driver, watchdog
////////////////////////////////////////
`include "tlu_cfg.svh"

module tb_tlu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS = 9;
    localparam int WATCHDOG_NS = (NROWS + 1) * 400 * 8;

    typedef struct packed {
        logic [7:0]  sel;     // trigger select
        logic [7:0]  inv;
        logic [7:0]  vsel;    // veto select
        logic [7:0]  vpins;
        logic [7:0]  pat;     // trigger pins for each pulse
        logic [3:0]  pulses;
        logic        ts;
        logic        ack;
        logic [31:0] load;    // counter preset, zero for none
        logic [3:0]  count;   // accepted triggers
        logic [31:0] first;   // first word in count mode
    } test_row_t;

    logic                   BUS_CLK;
    logic                   RST;
    logic [`TLU_ADDR_W-1:0] BUS_ADD;
    logic [`TLU_DATA_W-1:0] BUS_DATA_IN;
    logic                   BUS_RD;
    logic                   BUS_WR;
    logic [`TLU_DATA_W-1:0] BUS_DATA_OUT;
    logic                   FIFO_READ;
    logic                   FIFO_EMPTY;
    logic [`TLU_WORD_W-1:0] FIFO_DATA;
    logic [`TLU_LANES-1:0]  TRIGGER;
    logic [`TLU_LANES-1:0]  TRIGGER_VETO;
    logic                   TRIGGER_ENABLE;
    logic                   TRIGGER_ACKNOWLEDGE;
    logic                   TRIGGER_ACCEPTED_FLAG;
    logic                   TLU_BUSY;
    logic [`TLU_WORD_W-1:0] TIMESTAMP;
    test_row_t              rows [NROWS];
    string                  names [NROWS];
    logic [31:0]            rng = 32'd71600;

    tlu_core dut0 (.*);
    tb_tlu_checker chk0 (.*);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #4 BUS_CLK = ~BUS_CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge BUS_CLK);
            #1;
        end
    endtask

    task automatic wait_flag(input logic level, input int limit);
        int waited;
        waited = 0;
        while (TRIGGER_ACCEPTED_FLAG !== level && waited < limit)
        begin
            wait_cycles(1);
            waited++;
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        BUS_ADD = addr;
        BUS_DATA_IN = data;
        BUS_WR = 1'b1;
        wait_cycles(1);
        BUS_WR = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        BUS_ADD = addr;
        BUS_RD = 1'b1;
        wait_cycles(1);     // data registered on this edge
        BUS_RD = 1'b0;
        data = BUS_DATA_OUT;
    endtask

    task automatic fire(input logic [7:0] pattern, input logic ack);
        logic busy_before;
        int   delay;
        busy_before = TLU_BUSY;
        TRIGGER = pattern;
        if (busy_before)
        begin
            wait_cycles(10);    // edge has long reached the combiner
            chk0.check_value("busy while held", 1, TLU_BUSY);
        end
        else
        begin
            wait_flag(1'b1, 10);
            if (TRIGGER_ACCEPTED_FLAG && ack)
            begin
                rng = xorshift32(rng);
                delay = rng % 6;
                wait_cycles(delay);
                TRIGGER_ACKNOWLEDGE = 1'b1;
                wait_flag(1'b0, 10);
                if (TRIGGER_ACCEPTED_FLAG)
                    chk0.note_error("accepted flag did not fall after acknowledge");
                TRIGGER_ACKNOWLEDGE = 1'b0;
            end
        end
        // rearm with enable low so only rising pin edges count
        TRIGGER_ENABLE = 1'b0;
        TRIGGER = '0;
        wait_cycles(6);
        TRIGGER_ENABLE = 1'b1;
    endtask

    task automatic drain_fifo();
        int guard;
        guard = 0;
        while (!FIFO_EMPTY && guard < 2 * `TLU_FIFO_DEPTH)
        begin
            FIFO_READ = 1'b1;
            wait_cycles(1);
            guard++;
        end
        FIFO_READ = 1'b0;
    endtask

    task automatic run_row(input int r);
        test_row_t  row;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        int         exp_lost;
        row = rows[r];
        TRIGGER_ENABLE = 1'b0;
        TRIGGER = '0;
        TRIGGER_VETO = row.vpins;
        bus_write(`TLU_ADDR_RST_VER, 8'h00);    // soft reset between rows
        wait_cycles(2);
        chk0.start_test(names[r]);
        bus_write(`TLU_ADDR_TRIG_SEL, row.sel);
        bus_write(`TLU_ADDR_VETO_SEL, row.vsel);
        bus_write(`TLU_ADDR_TRIG_INV, row.inv);
        bus_write(`TLU_ADDR_CONF, {row.ts, 7'b0});
        if (row.load != 0)
        begin
            bus_write(`TLU_ADDR_CNT0, row.load[7:0]);
            bus_write(`TLU_ADDR_CNT1, row.load[15:8]);
            bus_write(`TLU_ADDR_CNT2, row.load[23:16]);
            bus_write(`TLU_ADDR_CNT3, row.load[31:24]);
        end
        wait_cycles(6);     // lanes settle with enable low
        TRIGGER_ENABLE = 1'b1;
        for (int p = 0; p < row.pulses; p++)
            fire(row.pat, row.ack);
        drain_fifo();
        exp_lost = (row.count > `TLU_FIFO_DEPTH) ? row.count - `TLU_FIFO_DEPTH : 0;
        bus_read(`TLU_ADDR_LOST, b0);
        chk0.check_value("lost count", exp_lost, b0);
        if (row.load != 0)
        begin
            bus_read(`TLU_ADDR_CNT0, b0);   // latches the upper bytes
            bus_read(`TLU_ADDR_CNT1, b1);
            bus_read(`TLU_ADDR_CNT2, b2);
            bus_read(`TLU_ADDR_CNT3, b3);
            chk0.check_value("counter readback", row.load + row.count, {b3, b2, b1, b0});
        end
        chk0.end_test(row.count, row.first, row.ts);
    endtask

    initial
    begin
        logic [7:0] rd_data;
        RST = 1'b1;
        BUS_ADD = '0;
        BUS_DATA_IN = '0;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        FIFO_READ = 1'b0;
        TRIGGER = '0;
        TRIGGER_VETO = '0;
        TRIGGER_ENABLE = 1'b0;
        TRIGGER_ACKNOWLEDGE = 1'b0;
        // sel, inv, vsel, vpins, pat, pulses, ts, ack, load, count, first
        rows[0] = '{'h08, 'h00, 'h00, 'h00, 'h08, 1, 0, 1, 0, 1, 'h8000_0000};
        rows[1] = '{'h08, 'h00, 'h00, 'h00, 'h10, 1, 0, 1, 0, 0, 0};
        rows[2] = '{'h04, 'h04, 'h00, 'h00, 'h04, 1, 0, 1, 0, 0, 0};
        rows[3] = '{'h01, 'h00, 'h02, 'h02, 'h01, 1, 0, 1, 0, 0, 0};
        rows[4] = '{'h01, 'h00, 'h00, 'h02, 'h01, 1, 0, 1, 0, 1, 'h8000_0000};
        rows[5] = '{'h01, 'h00, 'h00, 'h00, 'h01, 1, 0, 1, 'h1234_5678, 1, 'h9234_5678};
        rows[6] = '{'h01, 'h00, 'h00, 'h00, 'h01, 2, 0, 0, 0, 1, 'h8000_0000};
        rows[7] = '{'h01, 'h00, 'h00, 'h00, 'h01, 3, 1, 1, 0, 3, 0};
        rows[8] = '{'h01, 'h00, 'h00, 'h00, 'h01, 10, 0, 1, 0, 10, 'h8000_0000};
        names[0] = "sel_lane";
        names[1] = "unsel_lane";
        names[2] = "inverted";
        names[3] = "veto_on";
        names[4] = "veto_off";
        names[5] = "cnt_load";
        names[6] = "busy_hold";
        names[7] = "timestamp";
        names[8] = "overflow";
        repeat (5) @(posedge BUS_CLK);
        #1;
        RST = 1'b0;
        wait_cycles(2);
        chk0.start_test("reset_values");
        bus_read(`TLU_ADDR_RST_VER, rd_data);
        chk0.check_value("version", 2, rd_data);
        bus_read(`TLU_ADDR_VETO_SEL, rd_data);
        chk0.check_value("veto select", 'hff, rd_data);
        chk0.end_test(0, 0, 1'b0);
        for (int r = 0; r < NROWS; r++)
            run_row(r);
        chk0.report();
        if (chk0.errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
tlu_reg_pkg.sv
tlu_data_pkg.sv
tlu_regs.sv
trigger_lane.sv
trigger_accept.sv
trigger_fifo.sv
tlu_core.sv
tb_tlu_checker.sv
tb_tlu.sv
